/* hdl/jtag_pkg.sv */
package jtag_pkg;

    typedef logic [31:0] data_t;  // bus and shift word

    // register word offsets, base already removed
    localparam data_t ADDR_STATUS    = 32'd0;
    localparam data_t ADDR_SHIFT_OUT = 32'd1;  // read only
    localparam data_t ADDR_SHIFT_IN  = 32'd2;  // write only
    localparam data_t ADDR_CMD       = 32'd3;  // write only
    localparam data_t ADDR_SPEED     = 32'd4;
    localparam data_t ADDR_LAST      = 32'd4;

    // status register bits, the rest read as zero
    localparam int ST_OUT_CLR   = 0;
    localparam int ST_OUT_EMPTY = 1;
    localparam int ST_OUT_FULL  = 2;
    localparam int ST_IN_CLR    = 8;
    localparam int ST_IN_EMPTY  = 9;
    localparam int ST_IN_FULL   = 10;
    localparam int ST_CMD_CLR   = 16;
    localparam int ST_CMD_EMPTY = 17;
    localparam int ST_CMD_FULL  = 18;
    localparam int ST_DONE      = 24;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    localparam logic [3:0] CMD_IDLE  = 4'd0;  // tck periods, tms and tdi low
    localparam logic [3:0] CMD_TMS   = 4'd1;  // bits on tms
    localparam logic [3:0] CMD_SHIFT = 4'd2;  // bits on tdi, tdo captured

    typedef struct packed {
        logic [3:0]  opcode;     // top nibble of the word
        logic [27:0] cycle_num;
    } jtag_cmd_t;

    typedef struct packed {
        data_t      data;
        logic [3:0] strb;
    } bus_w_t;

    typedef struct packed {
        data_t      data;
        logic [1:0] resp;
    } bus_r_t;

    typedef struct packed {
        logic [15:0] high_period;  // upper half of the word
        logic [15:0] low_period;
    } speed_t;

endpackage

/* hdl/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 8
) (
    input  logic clk,
    input  logic jtag_rstn_sync,
    input  logic clear,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic full,
    output logic empty
);

    localparam int AW = $clog2(DEPTH);

    T           mem [DEPTH];
    logic [AW:0] wr_ptr;  // msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !clear) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr[AW-1:0]];  // head word, no read latency
    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

/* hdl/tck_timer.sv */
`timescale 1ns/1ps

module tck_timer (
    input  logic             clk,
    input  logic             jtag_rstn_sync,
    input  logic             run,
    input  jtag_pkg::speed_t speed,
    output logic             tck,
    output logic             fall_tick,
    output logic             rise_tick
);

    logic        active;     // inside a tck period
    logic [15:0] cnt;        // cycles left in this phase
    logic [15:0] low_load;
    logic [15:0] high_load;
    logic        phase_end;

    // a period of 0 behaves as 1
    assign low_load  = (speed.low_period == '0) ? '0 : speed.low_period - 16'd1;
    assign high_load = (speed.high_period == '0) ? '0 : speed.high_period - 16'd1;

    assign phase_end = active && (cnt == '0);
    assign rise_tick = phase_end && !tck;
    assign fall_tick = run && (!active || (phase_end && tck));

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            tck    <= 1'b0;
            active <= 1'b0;
            cnt    <= '0;
        end else if (fall_tick) begin
            tck    <= 1'b0;
            active <= 1'b1;
            cnt    <= low_load;
        end else if (rise_tick) begin
            tck <= 1'b1;
            cnt <= high_load;
        end else if (phase_end) begin
            tck    <= 1'b0;  // high phase over with run low, rest
            active <= 1'b0;
        end else if (active) begin
            cnt <= cnt - 16'd1;
        end
    end

endmodule

/* hdl/jtag_shift_fsm.sv */
`timescale 1ns/1ps

module jtag_shift_fsm (
    input  logic                clk,
    input  logic                jtag_rstn_sync,
    input  jtag_pkg::jtag_cmd_t cmd,
    input  logic                cmd_empty,
    input  jtag_pkg::data_t     in_word,
    input  logic                in_empty,
    input  logic                out_full,
    input  logic                tdo,
    input  logic                fall_tick,
    input  logic                rise_tick,
    output logic                cmd_pop,
    output logic                in_pop,
    output logic                out_push,
    output jtag_pkg::data_t     out_word,
    output logic                run,
    output logic                tms,
    output logic                tdi,
    output logic                engine_idle
);

    import jtag_pkg::*;

    typedef enum logic [2:0] {IDLE, LOAD, WAIT_DATA, DRIVE, SAMPLE, FLUSH} state_t;

    state_t      state;
    logic [3:0]  op;
    logic [27:0] bits_left;  // tck periods still to run
    logic [4:0]  bit_idx;    // next bit of the input word
    logic [4:0]  out_idx;    // next free bit of out_word
    logic        uses_data;
    logic        data_ok;
    logic        cur_bit;
    logic        load_ok;
    logic        finish;

    assign uses_data = (op == CMD_TMS) || (op == CMD_SHIFT);
    assign data_ok   = !uses_data || !in_empty;
    assign cur_bit   = in_word[bit_idx];

    assign load_ok = (cmd.cycle_num != '0)
                  && ((cmd.opcode == CMD_IDLE) || (cmd.opcode == CMD_TMS)
                   || (cmd.opcode == CMD_SHIFT));

    // last period of a command, the shift case ends through FLUSH
    assign finish = ((state == SAMPLE) && rise_tick && (bits_left == '0) && (op != CMD_SHIFT))
                 || ((state == FLUSH) && !out_full && (bits_left == '0));

    // command stays at the fifo head until it has run
    assign cmd_pop  = ((state == LOAD) && !load_ok) || finish;
    assign in_pop   = ((state == DRIVE) && fall_tick && uses_data && (bit_idx == 5'd31))
                   || (finish && uses_data && (bit_idx != '0));
    assign out_push = (state == FLUSH) && !out_full;

    assign run         = (state == DRIVE) || (state == SAMPLE);
    assign engine_idle = (state == IDLE);

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state     <= IDLE;
            op        <= CMD_IDLE;
            bits_left <= '0;
            bit_idx   <= '0;
            out_idx   <= '0;
            out_word  <= '0;
            tms       <= 1'b0;
            tdi       <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!cmd_empty) state <= LOAD;
                end
                LOAD: begin
                    op        <= cmd.opcode;
                    bits_left <= cmd.cycle_num;
                    state     <= load_ok ? WAIT_DATA : IDLE;
                end
                WAIT_DATA: begin
                    if (data_ok) state <= DRIVE;  // tck rests low meanwhile
                end
                DRIVE: begin
                    if (fall_tick) begin
                        tms       <= (op == CMD_TMS) ? cur_bit
                                   : ((op == CMD_SHIFT) && (bits_left == 28'd1));
                        tdi       <= (op == CMD_SHIFT) && cur_bit;
                        bits_left <= bits_left - 28'd1;
                        if (uses_data) bit_idx <= bit_idx + 5'd1;  // wraps as word pops
                        state     <= SAMPLE;
                    end
                end
                SAMPLE: begin
                    if (rise_tick) begin
                        if (op == CMD_SHIFT) begin
                            out_word[out_idx] <= tdo;
                            out_idx           <= out_idx + 5'd1;
                        end
                        if ((op == CMD_SHIFT) && ((out_idx == 5'd31) || (bits_left == '0))) begin
                            state <= FLUSH;
                        end else if (bits_left == '0) begin
                            state <= IDLE;
                        end else begin
                            state <= data_ok ? DRIVE : WAIT_DATA;
                        end
                    end
                end
                FLUSH: begin
                    if (!out_full) begin
                        out_word <= '0;  // upper bits of a partial word stay zero
                        out_idx  <= '0;
                        if (bits_left == '0) state <= IDLE;
                        else state <= data_ok ? DRIVE : WAIT_DATA;
                    end
                end
                default: state <= IDLE;
            endcase
            if (finish) bit_idx <= '0;  // rest of the input word is dropped
        end
    end

endmodule

/* hdl/bus_regs.sv */
`timescale 1ns/1ps

module bus_regs #(
    parameter jtag_pkg::data_t OFFSET_ADDR = 32'h1000_0000
) (
    input  logic             clk,
    input  logic             jtag_rstn_sync,
    input  jtag_pkg::data_t  wr_addr,
    input  logic             wr_addr_valid,
    output logic             wr_addr_ready,
    input  jtag_pkg::bus_w_t wr_data,
    input  logic             wr_data_valid,
    output logic             wr_data_ready,
    output logic [1:0]       wr_resp,
    output logic             wr_resp_valid,
    input  logic             wr_resp_ready,
    input  jtag_pkg::data_t  rd_addr,
    input  logic             rd_addr_valid,
    output logic             rd_addr_ready,
    output jtag_pkg::bus_r_t rd_data,
    output logic             rd_data_valid,
    input  logic             rd_data_ready,
    input  logic             in_full,
    input  logic             in_empty,
    input  logic             cmd_full,
    input  logic             cmd_empty,
    input  logic             out_full,
    input  logic             out_empty,
    input  jtag_pkg::data_t  out_word,
    input  logic             engine_idle,
    output logic             in_push,
    output logic             cmd_push,
    output jtag_pkg::data_t  push_word,
    output logic             out_pop,
    output logic             in_clear,
    output logic             cmd_clear,
    output logic             out_clear,
    output jtag_pkg::speed_t speed
);

    import jtag_pkg::*;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

    wr_state_t wr_state;
    rd_state_t rd_state;
    data_t     wr_off;
    data_t     rd_off;
    data_t     wr_idx;   // latched word offset
    data_t     rd_idx;
    logic      wr_err;   // held for the whole transfer
    logic      rd_err;
    logic      room;
    logic      wr_fire;
    logic      wr_ok;
    logic      rd_fire;
    data_t     status;

    assign wr_off = wr_addr - OFFSET_ADDR;
    assign rd_off = rd_addr - OFFSET_ADDR;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_state <= WR_IDLE;
            wr_idx   <= '0;
            wr_err   <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_addr_valid) begin
                        wr_idx   <= wr_off;
                        wr_err   <= (wr_off > ADDR_LAST) || (wr_off == ADDR_SHIFT_OUT);
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wr_fire) wr_state <= WR_RESP;
                end
                WR_RESP: begin
                    if (wr_resp_ready) wr_state <= WR_IDLE;
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_comb begin
        case (wr_idx)
            ADDR_SHIFT_IN: room = !in_full;
            ADDR_CMD:      room = !cmd_full;
            default:       room = 1'b1;  // registers and errors take the beat at once
        endcase
    end

    assign wr_addr_ready = (wr_state == WR_IDLE);
    assign wr_data_ready = (wr_state == WR_DATA) && room;
    assign wr_resp_valid = (wr_state == WR_RESP);
    assign wr_resp       = wr_err ? RESP_SLVERR : RESP_OKAY;

    assign wr_fire   = wr_data_valid && wr_data_ready;
    assign wr_ok     = wr_fire && !wr_err;
    assign in_push   = wr_ok && (wr_idx == ADDR_SHIFT_IN);
    assign cmd_push  = wr_ok && (wr_idx == ADDR_CMD);
    assign push_word = wr_data.data;

    // clear bits live for one cycle only
    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            out_clear <= 1'b0;
            in_clear  <= 1'b0;
            cmd_clear <= 1'b0;
        end else if (wr_ok && (wr_idx == ADDR_STATUS)) begin
            out_clear <= wr_data.strb[ST_OUT_CLR / 8] && wr_data.data[ST_OUT_CLR];
            in_clear  <= wr_data.strb[ST_IN_CLR / 8] && wr_data.data[ST_IN_CLR];
            cmd_clear <= wr_data.strb[ST_CMD_CLR / 8] && wr_data.data[ST_CMD_CLR];
        end else begin
            out_clear <= 1'b0;
            in_clear  <= 1'b0;
            cmd_clear <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            speed <= '{high_period: 16'd1, low_period: 16'd1};
        end else if (wr_ok && (wr_idx == ADDR_SPEED)) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_data.strb[b]) speed[8*b +: 8] <= wr_data.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            rd_state <= RD_IDLE;
            rd_idx   <= '0;
            rd_err   <= 1'b0;
        end else if (rd_state == RD_IDLE) begin
            if (rd_addr_valid) begin
                rd_idx   <= rd_off;
                rd_err   <= (rd_off > ADDR_LAST) || (rd_off == ADDR_SHIFT_IN)
                         || (rd_off == ADDR_CMD);
                rd_state <= RD_DATA;
            end
        end else if (rd_fire) begin
            rd_state <= RD_IDLE;
        end
    end

    assign rd_addr_ready = (rd_state == RD_IDLE);
    assign rd_data_valid = (rd_state == RD_DATA)
                        && ((rd_idx != ADDR_SHIFT_OUT) || !out_empty);
    assign rd_fire       = rd_data_valid && rd_data_ready;
    assign out_pop       = rd_fire && !rd_err && (rd_idx == ADDR_SHIFT_OUT);

    always_comb begin
        status               = '0;
        status[ST_OUT_CLR]   = out_clear;
        status[ST_OUT_EMPTY] = out_empty;
        status[ST_OUT_FULL]  = out_full;
        status[ST_IN_CLR]    = in_clear;
        status[ST_IN_EMPTY]  = in_empty;
        status[ST_IN_FULL]   = in_full;
        status[ST_CMD_CLR]   = cmd_clear;
        status[ST_CMD_EMPTY] = cmd_empty;
        status[ST_CMD_FULL]  = cmd_full;
        status[ST_DONE]      = cmd_empty && engine_idle;  // nothing queued or running
    end

    always_comb begin
        rd_data.resp = rd_err ? RESP_SLVERR : RESP_OKAY;
        case (rd_idx)
            ADDR_STATUS:    rd_data.data = status;
            ADDR_SHIFT_OUT: rd_data.data = out_word;
            ADDR_SPEED:     rd_data.data = speed;
            default:        rd_data.data = '1;  // every erroring read lands here
        endcase
    end

endmodule

/* hdl/jtag_slave_top.sv */
`timescale 1ns/1ps

module jtag_slave_top #(
    parameter jtag_pkg::data_t OFFSET_ADDR = 32'h1000_0000,
    parameter int              FIFO_DEPTH  = 8
) (
    input  logic             clk,
    input  logic             jtag_rstn_sync,
    input  logic             tdo,
    output logic             tck,
    output logic             tms,
    output logic             tdi,
    input  jtag_pkg::data_t  wr_addr,
    input  logic             wr_addr_valid,
    output logic             wr_addr_ready,
    input  jtag_pkg::bus_w_t wr_data,
    input  logic             wr_data_valid,
    output logic             wr_data_ready,
    output logic [1:0]       wr_resp,
    output logic             wr_resp_valid,
    input  logic             wr_resp_ready,
    input  jtag_pkg::data_t  rd_addr,
    input  logic             rd_addr_valid,
    output logic             rd_addr_ready,
    output jtag_pkg::bus_r_t rd_data,
    output logic             rd_data_valid,
    input  logic             rd_data_ready
);

    import jtag_pkg::*;

    data_t     push_word;  // host word for the in and cmd fifos
    data_t     in_word;
    data_t     eng_word;   // engine to out fifo
    data_t     rd_word;    // out fifo to the read mux
    jtag_cmd_t cmd;
    speed_t    speed;
    logic      in_push;
    logic      in_pop;
    logic      in_clear;
    logic      in_full;
    logic      in_empty;
    logic      cmd_push;
    logic      cmd_pop;
    logic      cmd_clear;
    logic      cmd_full;
    logic      cmd_empty;
    logic      out_push;
    logic      out_pop;
    logic      out_clear;
    logic      out_full;
    logic      out_empty;
    logic      engine_idle;
    logic      run;
    logic      fall_tick;
    logic      rise_tick;

    bus_regs #(.OFFSET_ADDR(OFFSET_ADDR)) bus_regs0 (.*, .out_word(rd_word));

    word_fifo #(.T(data_t), .DEPTH(FIFO_DEPTH)) in_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clear(in_clear),
        .push(in_push), .push_data(push_word), .pop(in_pop),
        .pop_data(in_word), .full(in_full), .empty(in_empty)
    );

    word_fifo #(.T(jtag_cmd_t), .DEPTH(FIFO_DEPTH)) cmd_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clear(cmd_clear),
        .push(cmd_push), .push_data(jtag_cmd_t'(push_word)), .pop(cmd_pop),
        .pop_data(cmd), .full(cmd_full), .empty(cmd_empty)
    );

    word_fifo #(.T(data_t), .DEPTH(FIFO_DEPTH)) out_fifo (
        .clk(clk), .jtag_rstn_sync(jtag_rstn_sync), .clear(out_clear),
        .push(out_push), .push_data(eng_word), .pop(out_pop),
        .pop_data(rd_word), .full(out_full), .empty(out_empty)
    );

    tck_timer tck_timer0 (.*);

    jtag_shift_fsm jtag_shift_fsm0 (.*, .out_word(eng_word));

endmodule

/* verification/tb_jtag_slave.sv */
`timescale 1ns/1ps

module tb_jtag_slave;

    import jtag_pkg::*;

    localparam data_t OFFSET_ADDR = 32'h4000_0000;
    localparam int    FIFO_DEPTH  = 4;
    localparam int    MAX_WAIT    = 1000;  // cycles per handshake
    localparam int    POLL_LIMIT  = 2000;  // status reads per done wait
    localparam int    ROW_CYCLES  = 3000;  // watchdog budget per table row
    localparam int    SHIFT_BITS  = 40;
    localparam int    SEL_WR_ADDR = 0;
    localparam int    SEL_WR_DATA = 1;
    localparam int    SEL_WR_RESP = 2;
    localparam int    SEL_RD_ADDR = 3;
    localparam int    SEL_RD_DATA = 4;

    typedef enum logic [2:0] {
        OP_WRITE, OP_STALL, OP_READ, OP_DONE, OP_EDGE_BASE, OP_EDGES, OP_TMS, OP_END
    } op_t;

    typedef struct packed {
        op_t        op;
        data_t      idx;   // register word offset
        data_t      data;
        logic [3:0] strb;
        data_t      exp;   // test number on OP_END rows
        logic [1:0] resp;
        data_t      mask;
    } step_t;

    logic        clk;
    logic        jtag_rstn_sync;
    logic        tdo;
    logic        tck;
    logic        tms;
    logic        tdi;
    data_t       wr_addr;
    logic        wr_addr_valid;
    logic        wr_addr_ready;
    bus_w_t      wr_data;
    logic        wr_data_valid;
    logic        wr_data_ready;
    logic [1:0]  wr_resp;
    logic        wr_resp_valid;
    logic        wr_resp_ready;
    data_t       rd_addr;
    logic        rd_addr_valid;
    logic        rd_addr_ready;
    bus_r_t      rd_data;
    logic        rd_data_valid;
    logic        rd_data_ready;

    step_t       steps[$];
    logic        tms_log[$];      // tms at every tck rise
    logic        table_built = 1'b0;
    logic [15:0] lfsr = 16'd79;
    bus_r_t      rd_seen;
    logic [1:0]  resp_seen;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;

    jtag_slave_top #(.OFFSET_ADDR(OFFSET_ADDR), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

    assign tdo = tdi;  // loopback

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge tck) tms_log.push_back(tms);

    initial begin
        wait (table_built);
        #(steps.size() * ROW_CYCLES * 10);
        $display("watchdog expired before the step table was finished");
        $display("Simulation FAILED");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic data_t lfsr_word();
        data_t w;
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr[15];
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
        return w;
    endfunction

    function automatic string test_title(input int n);
        case (n)
            1:       return "reset and registers";
            2:       return "error responses";
            3:       return "shift loopback";
            4:       return "tms and idle";
            5:       return "fifo clear";
            default: return "back-pressure";
        endcase
    endfunction

    function automatic data_t tms_pattern(input int base);
        data_t p;
        p = '0;
        for (int i = 0; i < 32; i++) begin
            if (base + i < tms_log.size()) p[i] = tms_log[base + i];
        end
        return p;
    endfunction

    task automatic check(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
        test_errors++;
    endtask

    task automatic write_row(input data_t idx, input data_t data, input logic [3:0] strb,
                             input logic [1:0] resp, input logic stall = 1'b0);
        step_t s;
        s      = '0;
        s.op   = stall ? OP_STALL : OP_WRITE;
        s.idx  = idx;
        s.data = data;
        s.strb = strb;
        s.resp = resp;
        steps.push_back(s);
    endtask

    task automatic read_row(input data_t idx, input data_t exp, input data_t mask,
                            input logic [1:0] resp);
        step_t s;
        s      = '0;
        s.op   = OP_READ;
        s.idx  = idx;
        s.exp  = exp;
        s.mask = mask;
        s.resp = resp;
        steps.push_back(s);
    endtask

    task automatic control_row(input op_t op, input data_t exp, input data_t mask);
        step_t s;
        s      = '0;
        s.op   = op;
        s.exp  = exp;
        s.mask = mask;
        steps.push_back(s);
    endtask

    task automatic build_table();
        data_t shift_w0;
        data_t shift_w1;
        data_t tms_w;
        data_t bp_words [FIFO_DEPTH];
        data_t bits;
        read_row(ADDR_STATUS, 32'h0102_0202, '1, RESP_OKAY);
        read_row(ADDR_SPEED, 32'h0001_0001, '1, RESP_OKAY);
        write_row(ADDR_SPEED, 32'hABCD_0003, 4'b0011, RESP_OKAY);  // low period only
        read_row(ADDR_SPEED, 32'h0001_0003, '1, RESP_OKAY);
        control_row(OP_END, 1, '0);
        read_row(ADDR_SHIFT_IN, '1, '1, RESP_SLVERR);
        read_row(ADDR_CMD, '1, '1, RESP_SLVERR);
        read_row(32'd9, '1, '1, RESP_SLVERR);
        write_row(ADDR_SHIFT_OUT, 32'h1234_5678, 4'hF, RESP_SLVERR);
        write_row(32'd9, 32'h1234_5678, 4'hF, RESP_SLVERR);
        control_row(OP_END, 2, '0);
        shift_w0 = lfsr_word();
        shift_w1 = lfsr_word();
        bits     = (32'd1 << (SHIFT_BITS - 32)) - 32'd1;  // bits left for word 1
        write_row(ADDR_SHIFT_IN, shift_w0, 4'hF, RESP_OKAY);
        write_row(ADDR_SHIFT_IN, shift_w1, 4'hF, RESP_OKAY);
        write_row(ADDR_CMD, {CMD_SHIFT, 28'(SHIFT_BITS)}, 4'hF, RESP_OKAY);
        control_row(OP_DONE, '0, '0);
        read_row(ADDR_SHIFT_OUT, shift_w0, '1, RESP_OKAY);
        read_row(ADDR_SHIFT_OUT, shift_w1 & bits, '1, RESP_OKAY);
        read_row(ADDR_STATUS, 32'd1 << ST_OUT_EMPTY, 32'd1 << ST_OUT_EMPTY, RESP_OKAY);
        control_row(OP_END, 3, '0);
        tms_w = lfsr_word();
        control_row(OP_EDGE_BASE, '0, '0);
        write_row(ADDR_SHIFT_IN, tms_w, 4'hF, RESP_OKAY);
        write_row(ADDR_CMD, {CMD_TMS, 28'd12}, 4'hF, RESP_OKAY);
        write_row(ADDR_CMD, {CMD_IDLE, 28'd5}, 4'hF, RESP_OKAY);
        control_row(OP_DONE, '0, '0);
        control_row(OP_EDGES, 32'd17, '1);
        control_row(OP_TMS, tms_w & 32'h0000_0FFF, 32'h0001_FFFF);  // 12 bits, then 5 zeros
        read_row(ADDR_STATUS, 32'd1 << ST_OUT_EMPTY, 32'd1 << ST_OUT_EMPTY, RESP_OKAY);
        control_row(OP_END, 4, '0);
        write_row(ADDR_SHIFT_IN, lfsr_word(), 4'hF, RESP_OKAY);
        write_row(ADDR_SHIFT_IN, lfsr_word(), 4'hF, RESP_OKAY);
        read_row(ADDR_STATUS, '0, 32'd1 << ST_IN_EMPTY, RESP_OKAY);
        write_row(ADDR_STATUS, 32'd1 << ST_IN_CLR, 4'b0010, RESP_OKAY);
        read_row(ADDR_STATUS, 32'd1 << ST_IN_EMPTY,
                 (32'd1 << ST_IN_EMPTY) | (32'd1 << ST_IN_CLR), RESP_OKAY);
        control_row(OP_END, 5, '0);
        write_row(ADDR_SPEED, 32'h0040_0040, 4'hF, RESP_OKAY);  // slow tck keeps cmds queued
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            write_row(ADDR_CMD, {CMD_SHIFT, 28'd1}, 4'hF, RESP_OKAY);
        end
        read_row(ADDR_STATUS, (32'd1 << ST_CMD_FULL) | (32'd1 << ST_IN_EMPTY),
                 (32'd1 << ST_CMD_FULL) | (32'd1 << ST_IN_EMPTY), RESP_OKAY);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            bp_words[i] = lfsr_word();
            write_row(ADDR_SHIFT_IN, bp_words[i], 4'hF, RESP_OKAY);
        end
        write_row(ADDR_CMD, {CMD_IDLE, 28'd1}, 4'hF, RESP_OKAY, 1'b1);
        control_row(OP_DONE, '0, '0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_row(ADDR_SHIFT_OUT, bp_words[i] & 32'd1, '1, RESP_OKAY);  // one bit each
        end
        read_row(ADDR_STATUS, 32'd1 << ST_OUT_EMPTY, 32'd1 << ST_OUT_EMPTY, RESP_OKAY);
        control_row(OP_END, 6, '0);
    endtask

    // samples mid-cycle, the transfer happens at the next rising edge
    task automatic wait_handshake(input int sel, output int waited);
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < MAX_WAIT) begin
            @(negedge clk);
            case (sel)
                SEL_WR_ADDR: seen = wr_addr_ready;
                SEL_WR_DATA: seen = wr_data_ready;
                SEL_WR_RESP: seen = wr_resp_valid;
                SEL_RD_ADDR: seen = rd_addr_ready;
                default:     seen = rd_data_valid;
            endcase
            rd_seen   = rd_data;
            resp_seen = wr_resp;
            if (!seen) waited++;
        end
        if (!seen) note_failure($sformatf("bus channel %0d gave no handshake in time", sel));
        @(posedge clk);
        #1;
    endtask

    task automatic apply_write(input step_t s);
        int waited;
        wr_addr       = OFFSET_ADDR + s.idx;
        wr_addr_valid = 1'b1;
        wait_handshake(SEL_WR_ADDR, waited);
        wr_addr_valid = 1'b0;
        wr_data       = '{data: s.data, strb: s.strb};
        wr_data_valid = 1'b1;
        wait_handshake(SEL_WR_DATA, waited);
        if (s.op == OP_STALL) check("wr_data_ready at first data cycle", data_t'(waited == 0), '0);
        wr_data_valid = 1'b0;
        wr_resp_ready = 1'b1;
        wait_handshake(SEL_WR_RESP, waited);
        wr_resp_ready = 1'b0;
        check("wr_resp", data_t'(resp_seen), data_t'(s.resp));
    endtask

    task automatic apply_read(input data_t idx, output bus_r_t r);
        int waited;
        rd_addr       = OFFSET_ADDR + idx;
        rd_addr_valid = 1'b1;
        wait_handshake(SEL_RD_ADDR, waited);
        rd_addr_valid = 1'b0;
        rd_data_ready = 1'b1;
        wait_handshake(SEL_RD_DATA, waited);
        rd_data_ready = 1'b0;
        r = rd_seen;
    endtask

    task automatic poll_done();
        bus_r_t r;
        int     polls;
        polls = 0;
        r     = '0;
        while (!r.data[ST_DONE] && polls < POLL_LIMIT) begin
            apply_read(ADDR_STATUS, r);
            polls++;
        end
        if (!r.data[ST_DONE]) note_failure("done bit never came up while polling status");
    endtask

    task automatic check_reset_outputs();
        @(negedge clk);
        check("tck", data_t'(tck), '0);
        check("tms", data_t'(tms), '0);
        check("tdi", data_t'(tdi), '0);
        check("wr_addr_ready", data_t'(wr_addr_ready), 32'd1);
        check("wr_data_ready", data_t'(wr_data_ready), '0);
        check("wr_resp_valid", data_t'(wr_resp_valid), '0);
        check("rd_addr_ready", data_t'(rd_addr_ready), 32'd1);
        check("rd_data_valid", data_t'(rd_data_valid), '0);
        @(posedge clk);
        #1;
    endtask

    initial begin
        bus_r_t r;
        int     edge_base;
        jtag_rstn_sync = 1'b0;
        wr_addr        = '0;
        wr_addr_valid  = 1'b0;
        wr_data        = '0;
        wr_data_valid  = 1'b0;
        wr_resp_ready  = 1'b0;
        rd_addr        = '0;
        rd_addr_valid  = 1'b0;
        rd_data_ready  = 1'b0;
        edge_base      = 0;
        build_table();
        table_built = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        jtag_rstn_sync = 1'b1;
        check_reset_outputs();
        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WRITE, OP_STALL: apply_write(steps[i]);
                OP_READ: begin
                    apply_read(steps[i].idx, r);
                    check($sformatf("rd_data.data (reg %0d)", steps[i].idx),
                          r.data & steps[i].mask, steps[i].exp & steps[i].mask);
                    check("rd_data.resp", data_t'(r.resp), data_t'(steps[i].resp));
                end
                OP_DONE:      poll_done();
                OP_EDGE_BASE: edge_base = tms_log.size();
                OP_EDGES:     check("tck rises", data_t'(tms_log.size() - edge_base), steps[i].exp);
                OP_TMS: begin
                    check("tms", tms_pattern(edge_base) & steps[i].mask,
                          steps[i].exp & steps[i].mask);
                end
                default: begin
                    $display("test %0d %s: %s, %0d errors", steps[i].exp,
                             test_title(int'(steps[i].exp)),
                             (test_errors == 0) ? "ok" : "failed", test_errors);
                    tests++;
                    test_errors = 0;
                end
            endcase
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/jtag_pkg.sv
hdl/word_fifo.sv
hdl/tck_timer.sv
hdl/jtag_shift_fsm.sv
hdl/bus_regs.sv
hdl/jtag_slave_top.sv
verification/tb_jtag_slave.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_jtag_slave \
    -f filelist.f -o tb_jtag_slave

sim_out=$(./obj_dir/tb_jtag_slave)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
